/* eth_rx_subsys.f */
verilog/xgmii_rx_pkg.sv
verilog/eth_crc32_step.sv
verilog/xgmii_lane_align.sv
verilog/eth_rx_frame_decode.sv
verilog/rx_stats_axil.sv
verilog/eth_rx_subsys.sv
sim/eth_rx_checker.sv
sim/rx_stream_monitor.sv
sim/tb_eth_rx_subsys.sv

/* sim/eth_rx_checker.sv */
//**********************************************************
// ethernet rx protocol checker
// concurrent assertions on the output stream, the status
// pulses and the AXI4-Lite response channels
//**********************************************************
`timescale 1ns/1ps

module eth_rx_checker (
    input logic                     clk,
    input logic                     reset_crc,
    input xgmii_rx_pkg::axis_beat_t m_axis,
    input xgmii_rx_pkg::rx_status_t status,
    input logic                     bvalid,
    input logic                     bready,
    input logic                     rvalid,
    input logic                     rready
);

    int fails = 0;

    // keep must look like 2^n - 1
    keep_contiguous: assert property (@(posedge clk) disable iff (reset_crc)
        m_axis.tvalid |-> (m_axis.tkeep != 8'h00) &&
                          ((m_axis.tkeep & (m_axis.tkeep + 8'd1)) == 8'h00))
    else begin
        fails++;
        $error("tkeep is empty or not contiguous from lane 0 on a valid beat");
    end

    status_on_last: assert property (@(posedge clk) disable iff (reset_crc)
        (|status) |-> (m_axis.tvalid && m_axis.tlast))
    else begin
        fails++;
        $error("status pulse without a tlast beat");
    end

    bvalid_held: assert property (@(posedge clk) disable iff (reset_crc)
        (bvalid && !bready) |=> bvalid)
    else begin
        fails++;
        $error("bvalid dropped before bready");
    end

    rvalid_held: assert property (@(posedge clk) disable iff (reset_crc)
        (rvalid && !rready) |=> rvalid)
    else begin
        fails++;
        $error("rvalid dropped before rready");
    end

endmodule

/* sim/rx_stream_monitor.sv */
//**********************************************************
// rx stream monitor
// rebuilds frames from the AXI-Stream beats and compares
// bytes, tuser and the last tkeep with the expected queue
//**********************************************************
`timescale 1ns/1ps

module rx_stream_monitor (
    input  logic                     clk,
    input  logic                     reset_crc,
    input  xgmii_rx_pkg::axis_beat_t m_axis,
    output int                       errors,
    output int                       frames_seen
);

    logic [7:0] exp_data[$];
    int         exp_len[$];
    bit         exp_user[$];
    string      exp_name[$];
    logic [7:0] act_data[$];

    task automatic add_byte(input logic [7:0] b);
        exp_data.push_back(b);
    endtask

    task automatic close_frame(input int len, input bit user, input string name);
        exp_len.push_back(len);
        exp_user.push_back(user);
        exp_name.push_back(name);
    endtask

    // final beat keep from the frame length
    function automatic logic [7:0] keep_for(input int len);
        if (len % 8 == 0) begin
            return 8'hFF;
        end
        return 8'((1 << (len % 8)) - 1);
    endfunction

    task automatic finish_frame(input logic tuser, input logic [7:0] keep);
        int         len;
        bit         user;
        string      name;
        logic [7:0] exp_b;
        bit         first_bad;

        if (exp_len.size() == 0) begin
            $display("output frame %0d arrived but no frame was expected", frames_seen);
            errors++;
        end else begin
            len       = exp_len.pop_front();
            user      = exp_user.pop_front();
            name      = exp_name.pop_front();
            first_bad = 1'b1;
            if (act_data.size() != len) begin
                $display("ERROR %s frame %0d length: expected %0d, actual %0d",
                         name, frames_seen, len, act_data.size());
                errors++;
            end
            for (int i = 0; i < len; i++) begin
                exp_b = exp_data.pop_front();
                // only the first wrong byte of a frame is shown
                if (first_bad && i < act_data.size() && act_data[i] !== exp_b) begin
                    $display("ERROR %s frame %0d byte %0d: expected %02h, actual %02h",
                             name, frames_seen, i, exp_b, act_data[i]);
                    errors++;
                    first_bad = 1'b0;
                end
            end
            if (tuser !== user) begin
                $display("ERROR %s frame %0d tuser: expected %0b, actual %0b",
                         name, frames_seen, user, tuser);
                errors++;
            end
            if (keep !== keep_for(len)) begin
                $display("ERROR %s frame %0d last tkeep: expected %02h, actual %02h",
                         name, frames_seen, keep_for(len), keep);
                errors++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset_crc) begin
            act_data.delete();
            errors      = 0;
            frames_seen = 0;
        end else if (m_axis.tvalid) begin
            for (int l = 0; l < 8; l++) begin
                if (m_axis.tkeep[l]) begin
                    act_data.push_back(m_axis.tdata[l*8 +: 8]);
                end
            end
            if (!m_axis.tlast && m_axis.tkeep !== 8'hFF) begin
                $display("ERROR beat tkeep inside frame %0d: expected ff, actual %02h",
                         frames_seen, m_axis.tkeep);
                errors++;
            end
            if (m_axis.tlast) begin
                finish_frame(m_axis.tuser, m_axis.tkeep);
                act_data.delete();
                frames_seen++;
            end
        end
    end

endmodule

/* sim/tb_eth_rx_subsys.sv */
//**********************************************************
// testbench for the 10G ethernet rx subsystem
// random XGMII frames in lane 0 and lane 4, bad FCS and
// error characters, then statistics over AXI4-Lite
//**********************************************************
`timescale 1ns/1ps

module tb_eth_rx_subsys;

    localparam int N_LANE0  = 40;
    localparam int N_LANE4  = 40;
    localparam int N_TERM   = 16;
    localparam int N_FCS    = 20;
    localparam int N_ERR    = 10;
    localparam int N_FRAMES = N_LANE0 + N_LANE4 + N_TERM + N_FCS + N_ERR;

    logic                      clk;
    logic                      reset_crc;
    xgmii_rx_pkg::xgmii_word_t xgmii_in;
    xgmii_rx_pkg::axis_beat_t  m_axis;
    xgmii_rx_pkg::axil_addr_t  awaddr;
    logic                      awvalid;
    logic                      awready;
    logic [31:0]               wdata;
    logic [3:0]                wstrb;
    logic                      wvalid;
    logic                      wready;
    logic [1:0]                bresp;
    logic                      bvalid;
    logic                      bready;
    xgmii_rx_pkg::axil_addr_t  araddr;
    logic                      arvalid;
    logic                      arready;
    logic [31:0]               rdata;
    logic [1:0]                rresp;
    logic                      rvalid;
    logic                      rready;
    int                        stream_errors;
    int                        frames_seen;
    int                        reg_errors;
    int                        exp_ok;
    int                        exp_bad;
    int                        exp_fcs;

    eth_rx_subsys i_eth_rx_subsys (
        .clk (clk), .reset_crc (reset_crc), .xgmii_in (xgmii_in), .m_axis (m_axis),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready)
    );

    rx_stream_monitor i_rx_stream_monitor (
        .clk (clk), .reset_crc (reset_crc), .m_axis (m_axis),
        .errors (stream_errors), .frames_seen (frames_seen)
    );

    bind eth_rx_subsys eth_rx_checker i_eth_rx_checker (
        .clk (clk), .reset_crc (reset_crc), .m_axis (m_axis), .status (status),
        .bvalid (bvalid), .bready (bready), .rvalid (rvalid), .rready (rready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // bit-serial reflected CRC-32 over one byte, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        logic        fb;

        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c  = c >> 1;
            if (fb) begin
                c = c ^ 32'hEDB8_8320;
            end
        end
        return c;
    endfunction

    task automatic send_frame(input string name, input int len, input bit lane4,
                              input bit flip, input bit err_char, input int gap);
        logic [7:0]                frame[$];
        logic [8:0]                lanes[$];
        logic [31:0]               crc;
        int                        pos;
        int                        exp_len;
        xgmii_rx_pkg::xgmii_word_t w;

        crc = 32'hFFFF_FFFF;
        for (int i = 0; i < len; i++) begin
            frame.push_back(8'($urandom));
            crc = crc_byte(crc, frame[i]);
        end
        // FCS goes out least significant byte first
        for (int k = 0; k < 4; k++) begin
            frame.push_back(~crc[k*8 +: 8]);
        end
        if (flip) begin
            pos        = $urandom_range(len - 1, 0);
            frame[pos] = frame[pos] ^ (8'h01 << $urandom_range(7, 0));
        end
        pos     = err_char ? $urandom_range(frame.size() - 1, 1) : frame.size();
        exp_len = pos;
        for (int i = 0; i < exp_len; i++) begin
            i_rx_stream_monitor.add_byte(frame[i]);
        end
        i_rx_stream_monitor.close_frame(exp_len, flip || err_char, name);
        if (flip) begin
            exp_bad++;
            exp_fcs++;
        end else if (err_char) begin
            exp_bad++;
        end else begin
            exp_ok++;
        end

        // lane stream of {ctrl, byte}
        if (lane4) begin
            repeat (4) lanes.push_back({1'b1, xgmii_rx_pkg::XGMII_IDLE});
        end
        lanes.push_back({1'b1, xgmii_rx_pkg::XGMII_START});
        repeat (6) lanes.push_back({1'b0, 8'h55});
        lanes.push_back({1'b0, 8'hD5});
        for (int i = 0; i < frame.size(); i++) begin
            if (i == pos) begin
                lanes.push_back({1'b1, xgmii_rx_pkg::XGMII_ERROR});
            end else begin
                lanes.push_back({1'b0, frame[i]});
            end
        end
        lanes.push_back({1'b1, xgmii_rx_pkg::XGMII_TERM});
        while (lanes.size() % 8 != 0) begin
            lanes.push_back({1'b1, xgmii_rx_pkg::XGMII_IDLE});
        end
        repeat (gap * 8) lanes.push_back({1'b1, xgmii_rx_pkg::XGMII_IDLE});

        for (int base = 0; base < lanes.size(); base += 8) begin
            for (int l = 0; l < 8; l++) begin
                w.data[l*8 +: 8] = lanes[base + l][7:0];
                w.ctrl[l]        = lanes[base + l][8];
            end
            @(posedge clk);
            xgmii_in <= w;
        end
    endtask

    task automatic axil_read(input xgmii_rx_pkg::axil_addr_t addr,
                             output logic [31:0] data, output logic [1:0] resp);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        do begin
            @(posedge clk);
        end while (!arready);
        arvalid <= 1'b0;
        do begin
            @(posedge clk);
        end while (!rvalid);
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    task automatic axil_write(input string name, input xgmii_rx_pkg::axil_addr_t addr,
                              input logic [31:0] data);
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= 4'hF;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        do begin
            @(posedge clk);
        end while (!awready);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do begin
            @(posedge clk);
        end while (!bvalid);
        if (bresp !== xgmii_rx_pkg::AXI_RESP_OKAY) begin
            $display("ERROR %s response: expected %0d, actual %0d", name, 0, bresp);
            reg_errors++;
        end
        bready <= 1'b0;
    endtask

    task automatic check_reg(input string name, input xgmii_rx_pkg::axil_addr_t addr,
                             input logic [31:0] expected);
        logic [31:0] data;
        logic [1:0]  resp;

        axil_read(addr, data, resp);
        if (data !== expected) begin
            $display("ERROR %s: expected %0d, actual %0d", name, expected, data);
            reg_errors++;
        end
        if (resp !== xgmii_rx_pkg::AXI_RESP_OKAY) begin
            $display("ERROR %s response: expected %0d, actual %0d", name, 0, resp);
            reg_errors++;
        end
    endtask

    initial begin : stimulus
        int total;

        xgmii_in   = xgmii_rx_pkg::XGMII_IDLE_WORD;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        reg_errors = 0;
        exp_ok     = 0;
        exp_bad    = 0;
        exp_fcs    = 0;
        void'($urandom(91));
        reset_crc = 1'b1;
        repeat (5) @(posedge clk);
        reset_crc <= 1'b0;
        repeat (4) @(posedge clk);

        for (int i = 0; i < N_LANE0; i++) begin
            send_frame("lane0_good", $urandom_range(120, 60), 1'b0, 1'b0, 1'b0,
                       $urandom_range(4, 1));
        end
        // every other lane-4 frame uses the one-idle gap
        for (int i = 0; i < N_LANE4; i++) begin
            send_frame("lane4_good", $urandom_range(120, 60), 1'b1, 1'b0, 1'b0,
                       (i % 2 == 0) ? 1 : $urandom_range(4, 1));
        end
        // frame lengths 64 to 79 hit every terminate lane twice
        for (int i = 0; i < N_TERM; i++) begin
            send_frame("term_lane", 60 + i, 1'(i % 2), 1'b0, 1'b0, 1);
        end
        for (int i = 0; i < N_FCS; i++) begin
            send_frame("bad_fcs", $urandom_range(120, 60), 1'($urandom_range(1, 0)),
                       1'b1, 1'b0, $urandom_range(4, 1));
        end
        for (int i = 0; i < N_ERR; i++) begin
            send_frame("err_char", $urandom_range(120, 60), 1'($urandom_range(1, 0)),
                       1'b0, 1'b1, $urandom_range(4, 1));
        end

        wait (frames_seen == N_FRAMES);
        repeat (4) @(posedge clk);

        check_reg("frames_ok", xgmii_rx_pkg::REG_FRAMES_OK, exp_ok);
        check_reg("frames_bad", xgmii_rx_pkg::REG_FRAMES_BAD, exp_bad);
        check_reg("fcs_err", xgmii_rx_pkg::REG_FCS_ERR, exp_fcs);
        axil_write("clear", xgmii_rx_pkg::REG_CLEAR, 32'h1);
        check_reg("frames_ok_cleared", xgmii_rx_pkg::REG_FRAMES_OK, 0);
        check_reg("frames_bad_cleared", xgmii_rx_pkg::REG_FRAMES_BAD, 0);
        check_reg("fcs_err_cleared", xgmii_rx_pkg::REG_FCS_ERR, 0);
        check_reg("unmapped", 8'h20, 0);

        repeat (2) @(posedge clk);
        total = stream_errors + reg_errors + i_eth_rx_subsys.i_eth_rx_checker.fails;
        $display("stream errors: %0d, register errors: %0d, assertion failures: %0d",
                 stream_errors, reg_errors, i_eth_rx_subsys.i_eth_rx_checker.fails);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (N_FRAMES * 200 + 1000) @(posedge clk);
        $display("run timed out before all frames and register accesses finished");
        $display("Something failed");
        $finish;
    end

endmodule

/* verilog/eth_crc32_step.sv */
//**********************************************************
// ethernet CRC-32 step
// advances the reflected CRC over 1 to 8 bytes of a word,
// lane 0 first, in one combinational pass
//**********************************************************
`timescale 1ns/1ps

module eth_crc32_step (
    input  xgmii_rx_pkg::data64_t data_in,
    input  logic [3:0]            byte_count,
    input  xgmii_rx_pkg::crc32_t  crc_in,
    output xgmii_rx_pkg::crc32_t  crc_out
);

    always_comb begin : crc_calc
        xgmii_rx_pkg::crc32_t crc;

        crc = crc_in;
        for (int b = 0; b < 8; b++) begin
            // bytes past byte_count leave the state alone
            if (4'(b) < byte_count) begin
                crc = crc ^ {24'd0, data_in[b*8 +: 8]};
                for (int k = 0; k < 8; k++) begin
                    if (crc[0]) begin
                        crc = (crc >> 1) ^ xgmii_rx_pkg::CRC_POLY;
                    end else begin
                        crc = crc >> 1;
                    end
                end
            end
        end
        crc_out = crc;
    end

endmodule

/* verilog/eth_rx_frame_decode.sv */
//**********************************************************
// ethernet rx frame decoder
// strips the start word, cuts frames at the terminate
// character, checks the FCS and emits AXI-Stream beats
//**********************************************************
`timescale 1ns/1ps

module eth_rx_frame_decode (
    input  logic                      clk,
    input  logic                      reset_crc,
    input  xgmii_rx_pkg::xgmii_word_t aligned,
    output xgmii_rx_pkg::axis_beat_t  m_axis,
    output xgmii_rx_pkg::rx_status_t  status
);

    xgmii_rx_pkg::rx_state_t   state;
    xgmii_rx_pkg::rx_state_t   state_next;
    xgmii_rx_pkg::xgmii_word_t d0;
    xgmii_rx_pkg::xgmii_word_t d1;
    xgmii_rx_pkg::crc32_t      crc_state;
    xgmii_rx_pkg::crc32_t      crc_next;
    xgmii_rx_pkg::crc32_t      crc_full;
    xgmii_rx_pkg::crc32_t      crc_part;
    xgmii_rx_pkg::axis_beat_t  beat_next;
    xgmii_rx_pkg::rx_status_t  status_next;
    xgmii_rx_pkg::lane8_t      d1_term;
    xgmii_rx_pkg::lane8_t      d1_keep;
    logic [3:0]                d1_first;
    logic                      d1_start;
    logic                      d1_ends_ok;
    logic                      d0_term0;

    // lowest control lane of d1, 8 when the word is all data
    always_comb begin
        d1_first = 4'd8;
        for (int i = 7; i >= 0; i--) begin
            d1_term[i] = d1.ctrl[i] && (d1.data[i*8 +: 8] == xgmii_rx_pkg::XGMII_TERM);
            if (d1.ctrl[i]) begin
                d1_first = 4'(i);
            end
        end
        for (int i = 0; i < 8; i++) begin
            d1_keep[i] = 4'(i) < d1_first;
        end
    end

    assign d1_start   = d1.ctrl[0] && (d1.data[7:0] == xgmii_rx_pkg::XGMII_START);
    assign d1_ends_ok = (d1_first < 4'd8) && d1_term[d1_first[2:0]];
    assign d0_term0   = d0.ctrl[0] && (d0.data[7:0] == xgmii_rx_pkg::XGMII_TERM);

    eth_crc32_step i_crc_full (
        .data_in    (d1.data),
        .byte_count (4'd8),
        .crc_in     (crc_state),
        .crc_out    (crc_full)
    );

    // final word, bytes below the first control lane
    eth_crc32_step i_crc_part (
        .data_in    (d1.data),
        .byte_count (d1_first),
        .crc_in     (crc_state),
        .crc_out    (crc_part)
    );

    always_comb begin
        state_next       = state;
        crc_next         = xgmii_rx_pkg::CRC_INIT;
        beat_next.tdata  = d1.data;
        beat_next.tkeep  = 8'h00;
        beat_next.tvalid = 1'b0;
        beat_next.tlast  = 1'b0;
        beat_next.tuser  = 1'b0;
        status_next      = '0;

        case (state)
            xgmii_rx_pkg::RX_IDLE: begin
                if (d1_start) begin
                    if (d0.ctrl == 8'h00) begin
                        state_next = xgmii_rx_pkg::RX_PAYLOAD;
                    end else if (!d0.ctrl[0]) begin
                        state_next = xgmii_rx_pkg::RX_LAST;
                    end else begin
                        // no data bytes at all
                        beat_next.tkeep       = 8'h01;
                        beat_next.tvalid      = 1'b1;
                        beat_next.tlast       = 1'b1;
                        beat_next.tuser       = 1'b1;
                        status_next.bad_frame = 1'b1;
                    end
                end
            end
            xgmii_rx_pkg::RX_PAYLOAD: begin
                beat_next.tkeep  = 8'hFF;
                beat_next.tvalid = 1'b1;
                crc_next         = crc_full;
                if (d0.ctrl != 8'h00 && !d0.ctrl[0]) begin
                    state_next = xgmii_rx_pkg::RX_LAST;
                end else if (d0.ctrl[0]) begin
                    // next word opens with a control character
                    beat_next.tlast = 1'b1;
                    crc_next        = xgmii_rx_pkg::CRC_INIT;
                    state_next      = xgmii_rx_pkg::RX_IDLE;
                    if (d0_term0 && crc_full == xgmii_rx_pkg::CRC_RESIDUE) begin
                        status_next.frame_good = 1'b1;
                    end else begin
                        beat_next.tuser       = 1'b1;
                        status_next.bad_frame = 1'b1;
                        status_next.bad_fcs   = d0_term0;
                    end
                end
            end
            xgmii_rx_pkg::RX_LAST: begin
                beat_next.tkeep  = d1_keep;
                beat_next.tvalid = 1'b1;
                beat_next.tlast  = 1'b1;
                state_next       = xgmii_rx_pkg::RX_IDLE;
                if (d1_ends_ok && crc_part == xgmii_rx_pkg::CRC_RESIDUE) begin
                    status_next.frame_good = 1'b1;
                end else begin
                    // error or stray control before the terminate
                    beat_next.tuser       = 1'b1;
                    status_next.bad_frame = 1'b1;
                    status_next.bad_fcs   = d1_ends_ok;
                end
            end
            default: begin
                state_next = xgmii_rx_pkg::RX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state         <= xgmii_rx_pkg::RX_IDLE;
            d0            <= xgmii_rx_pkg::XGMII_IDLE_WORD;
            d1            <= xgmii_rx_pkg::XGMII_IDLE_WORD;
            crc_state     <= xgmii_rx_pkg::CRC_INIT;
            m_axis.tvalid <= 1'b0;
            status        <= '0;
        end else begin
            state         <= state_next;
            d0            <= aligned;
            d1            <= d0;
            crc_state     <= crc_next;
            m_axis.tvalid <= beat_next.tvalid;
            status        <= status_next;
        end
        m_axis.tdata <= beat_next.tdata;
        m_axis.tkeep <= beat_next.tkeep;
        m_axis.tlast <= beat_next.tlast;
        m_axis.tuser <= beat_next.tuser;
    end

endmodule

/* verilog/eth_rx_subsys.sv */
//**********************************************************
// 10G ethernet rx subsystem
// lane aligner, frame decoder and statistics registers
//**********************************************************
`timescale 1ns/1ps

module eth_rx_subsys (
    input  logic                      clk,
    input  logic                      reset_crc,
    input  xgmii_rx_pkg::xgmii_word_t xgmii_in,
    output xgmii_rx_pkg::axis_beat_t  m_axis,
    input  xgmii_rx_pkg::axil_addr_t  awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               wdata,
    input  logic [3:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  xgmii_rx_pkg::axil_addr_t  araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready
);

    xgmii_rx_pkg::xgmii_word_t aligned;
    xgmii_rx_pkg::rx_status_t  status;

    xgmii_lane_align i_xgmii_lane_align (
        .clk       (clk),
        .reset_crc (reset_crc),
        .xgmii_in  (xgmii_in),
        .aligned   (aligned)
    );

    eth_rx_frame_decode i_eth_rx_frame_decode (
        .clk       (clk),
        .reset_crc (reset_crc),
        .aligned   (aligned),
        .m_axis    (m_axis),
        .status    (status)
    );

    rx_stats_axil i_rx_stats_axil (
        .clk       (clk),
        .reset_crc (reset_crc),
        .status    (status),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready)
    );

endmodule

/* verilog/rx_stats_axil.sv */
//**********************************************************
// rx frame statistics
// counts good, bad and FCS-error frames and serves them
// over an AXI4-Lite slave, with a write command to clear
//**********************************************************
`timescale 1ns/1ps

module rx_stats_axil (
    input  logic                     clk,
    input  logic                     reset_crc,
    input  xgmii_rx_pkg::rx_status_t status,
    input  xgmii_rx_pkg::axil_addr_t awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [31:0]              wdata,
    input  logic [3:0]               wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  xgmii_rx_pkg::axil_addr_t araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [31:0]              rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready
);

    xgmii_rx_pkg::count32_t frames_ok;
    xgmii_rx_pkg::count32_t frames_bad;
    xgmii_rx_pkg::count32_t fcs_err;
    xgmii_rx_pkg::count32_t rd_mux;
    logic                   wr_accept;
    logic                   rd_accept;
    logic                   clear_hit;

    assign wr_accept = awvalid && awready && wvalid && wready;
    assign rd_accept = arvalid && arready;

    // bit 0 written to the clear register zeroes every counter
    assign clear_hit = wr_accept && (awaddr == xgmii_rx_pkg::REG_CLEAR) &&
                       wstrb[0] && wdata[0];

    assign bresp = xgmii_rx_pkg::AXI_RESP_OKAY;
    assign rresp = xgmii_rx_pkg::AXI_RESP_OKAY;

    always_comb begin
        case (araddr)
            xgmii_rx_pkg::REG_FRAMES_OK:  rd_mux = frames_ok;
            xgmii_rx_pkg::REG_FRAMES_BAD: rd_mux = frames_bad;
            xgmii_rx_pkg::REG_FCS_ERR:    rd_mux = fcs_err;
            default:                      rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc || clear_hit) begin
            frames_ok  <= '0;
            frames_bad <= '0;
            fcs_err    <= '0;
        end else begin
            frames_ok  <= frames_ok + 32'(status.frame_good);
            frames_bad <= frames_bad + 32'(status.bad_frame || status.bad_fcs);
            fcs_err    <= fcs_err + 32'(status.bad_fcs);
        end
    end

    // write channel, AW and W taken together
    always_ff @(posedge clk) begin
        if (reset_crc) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (awready) begin
                awready <= 1'b0;
                wready  <= 1'b0;
                bvalid  <= wr_accept;
            end else if (awvalid && wvalid && !bvalid) begin
                awready <= 1'b1;
                wready  <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // read channel, data snapshot taken at AR acceptance
    always_ff @(posedge clk) begin
        if (reset_crc) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (arready) begin
                arready <= 1'b0;
                rvalid  <= rd_accept;
            end else if (arvalid && !rvalid) begin
                arready <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
        if (rd_accept) begin
            rdata <= rd_mux;
        end
    end

endmodule

/* verilog/xgmii_lane_align.sv */
//**********************************************************
// XGMII lane aligner
// registers the incoming word and shifts frames that start
// in lane 4 down by half a word so they start in lane 0
//**********************************************************
`timescale 1ns/1ps

module xgmii_lane_align (
    input  logic                      clk,
    input  logic                      reset_crc,
    input  xgmii_rx_pkg::xgmii_word_t xgmii_in,
    output xgmii_rx_pkg::xgmii_word_t aligned
);

    logic        start_lane0;
    logic        start_lane4;
    logic        swapped;
    logic [31:0] hold_data;
    logic [3:0]  hold_ctrl;

    assign start_lane0 = xgmii_in.ctrl[0] &&
                         (xgmii_in.data[7:0] == xgmii_rx_pkg::XGMII_START);
    assign start_lane4 = xgmii_in.ctrl[4] &&
                         (xgmii_in.data[39:32] == xgmii_rx_pkg::XGMII_START);

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            swapped   <= 1'b0;
            aligned   <= xgmii_rx_pkg::XGMII_IDLE_WORD;
            hold_data <= {4{xgmii_rx_pkg::XGMII_IDLE}};
            hold_ctrl <= 4'hF;
        end else begin
            // upper half kept for the shifted output
            hold_data <= xgmii_in.data[63:32];
            hold_ctrl <= xgmii_in.ctrl[7:4];

            if (start_lane0) begin
                swapped <= 1'b0;
                aligned <= xgmii_in;
            end else if (swapped) begin
                // previous upper half becomes lanes 0 to 3
                aligned.data <= {xgmii_in.data[31:0], hold_data};
                aligned.ctrl <= {xgmii_in.ctrl[3:0], hold_ctrl};
            end else if (start_lane4) begin
                // lower half may still end the last frame, upper half idles
                swapped      <= 1'b1;
                aligned.data <= {{4{xgmii_rx_pkg::XGMII_IDLE}}, xgmii_in.data[31:0]};
                aligned.ctrl <= {4'hF, xgmii_in.ctrl[3:0]};
            end else begin
                aligned <= xgmii_in;
            end
        end
    end

endmodule

/* verilog/xgmii_rx_pkg.sv */
//**********************************************************
// xgmii rx shared definitions
// widths, XGMII control codes, CRC constants, register map,
// structs and the decoder state encoding
//**********************************************************
package xgmii_rx_pkg;

    typedef logic [63:0] data64_t;
    typedef logic [7:0]  lane8_t;
    typedef logic [31:0] crc32_t;
    typedef logic [31:0] count32_t;
    typedef logic [7:0]  axil_addr_t;

    // XGMII control characters
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hFB;
    localparam logic [7:0] XGMII_TERM  = 8'hFD;
    localparam logic [7:0] XGMII_ERROR = 8'hFE;

    // reflected ethernet polynomial, residue over data plus FCS
    localparam crc32_t CRC_INIT    = 32'hFFFF_FFFF;
    localparam crc32_t CRC_POLY    = 32'hEDB8_8320;
    localparam crc32_t CRC_RESIDUE = 32'hDEBB_20E3;

    // statistics register map
    localparam axil_addr_t REG_FRAMES_OK  = 8'h00;
    localparam axil_addr_t REG_FRAMES_BAD = 8'h04;
    localparam axil_addr_t REG_FCS_ERR    = 8'h08;
    localparam axil_addr_t REG_CLEAR      = 8'h0C;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef struct packed {
        data64_t data;
        lane8_t  ctrl;
    } xgmii_word_t;

    localparam xgmii_word_t XGMII_IDLE_WORD = '{data: {8{XGMII_IDLE}}, ctrl: 8'hFF};

    typedef struct packed {
        data64_t tdata;
        lane8_t  tkeep;
        logic    tvalid;
        logic    tlast;
        logic    tuser;
    } axis_beat_t;

    typedef struct packed {
        logic frame_good;
        logic bad_frame;
        logic bad_fcs;
    } rx_status_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PAYLOAD,
        RX_LAST
    } rx_state_t;

endpackage
